// File: Bender.yml
package:
  name: hci_pio

sources:
  # Design
  - hw/hci_pkg.sv
  - hw/hci_queue_if.sv
  - hw/hci_fifo.sv
  - hw/hci_write_queue.sv
  - hw/hci_read_queue.sv
  - hw/hci_csr_ctrl.sv
  - hw/hci_pio.sv

  # Verification
  - target: simulation
    files:
      - verification/hci_tb_clk_gen.sv
      - verification/hci_pio_properties.sv
      - verification/hci_pio_tb.sv

// File: hw/hci_csr_ctrl.sv
/* Register decode, threshold and queue-reset registers,
   reset sequencers and acknowledge merging */
`timescale 1ns/1ns

module hci_csr_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       csr_req_i,
  input  logic                       csr_wr_i,
  input  logic [hci_pkg::ADDR_W-1:0] csr_addr_i,
  input  logic [hci_pkg::DATA_W-1:0] csr_wdata_i,
  output logic                       csr_wr_ack_o,
  output logic                       csr_rd_ack_o,
  output logic                       csr_err_o,
  output logic [hci_pkg::DATA_W-1:0] csr_rdata_o,
  hci_queue_if.ctrl                  cmd_q,
  hci_queue_if.ctrl                  resp_q,
  hci_queue_if.ctrl                  tx_q,
  hci_queue_if.ctrl                  rx_q
);
  import hci_pkg::*;

  csr_sel_e              sel;
  logic                  port_req, own_req, own_wr, own_err;
  logic [DATA_W-1:0]     own_rdata, queue_status;
  logic                  own_ack_q, own_err_q, wr_pend_q;
  logic [DATA_W-1:0]     own_rdata_q;
  logic [THLD_W-1:0]     cmd_thld_q, resp_thld_q, tx_thld_q, rx_thld_q;
  rst_state_e            rst_state_q [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] rst_set, rst_bits, flush_q, flush_done;
  logic                  any_ack;

  always_comb begin
    case (csr_addr_i)
      ADDR_COMMAND_PORT:       sel = SEL_COMMAND_PORT;
      ADDR_RESPONSE_PORT:      sel = SEL_RESPONSE_PORT;
      ADDR_XFER_DATA_PORT:     sel = SEL_XFER_DATA_PORT;
      ADDR_QUEUE_THLD_CTRL:    sel = SEL_QUEUE_THLD_CTRL;
      ADDR_DATA_BUF_THLD_CTRL: sel = SEL_DATA_BUF_THLD_CTRL;
      ADDR_RESET_CONTROL:      sel = SEL_RESET_CONTROL;
      ADDR_QUEUE_STATUS:       sel = SEL_QUEUE_STATUS;
      default:                 sel = SEL_NONE;
    endcase
  end

  // Port accesses go to the queues, XFER split by direction
  assign cmd_q.req  = csr_req_i & csr_wr_i & (sel == SEL_COMMAND_PORT);
  assign resp_q.req = csr_req_i & ~csr_wr_i & (sel == SEL_RESPONSE_PORT);
  assign tx_q.req   = csr_req_i & csr_wr_i & (sel == SEL_XFER_DATA_PORT);
  assign rx_q.req   = csr_req_i & ~csr_wr_i & (sel == SEL_XFER_DATA_PORT);

  assign cmd_q.wdata  = csr_wdata_i;
  assign resp_q.wdata = csr_wdata_i;
  assign tx_q.wdata   = csr_wdata_i;
  assign rx_q.wdata   = csr_wdata_i;

  assign port_req = cmd_q.req | resp_q.req | tx_q.req | rx_q.req;
  assign own_req  = csr_req_i & ~port_req;  // Answered here
  assign own_wr   = own_req & csr_wr_i;

  // Unknown address or wrong direction on a queue port
  always_comb begin
    case (sel)
      SEL_NONE:          own_err = 1'b1;
      SEL_COMMAND_PORT:  own_err = ~csr_wr_i;
      SEL_RESPONSE_PORT: own_err = csr_wr_i;
      SEL_QUEUE_STATUS:  own_err = csr_wr_i;  // Read-only
      default:           own_err = 1'b0;
    endcase
  end

  always_comb begin
    queue_status = '0;
    queue_status[Q_CMD]  = cmd_q.empty;
    queue_status[Q_RESP] = resp_q.empty;
    queue_status[Q_TX]   = tx_q.empty;
    queue_status[Q_RX]   = rx_q.empty;
    queue_status[STATUS_FULL_LSB + Q_CMD]  = cmd_q.full;
    queue_status[STATUS_FULL_LSB + Q_RESP] = resp_q.full;
    queue_status[STATUS_FULL_LSB + Q_TX]   = tx_q.full;
    queue_status[STATUS_FULL_LSB + Q_RX]   = rx_q.full;
  end

  always_comb begin
    own_rdata = '0;
    case (sel)
      SEL_QUEUE_THLD_CTRL: begin
        own_rdata[THLD_LO_LSB +: THLD_W] = cmd_thld_q;
        own_rdata[THLD_HI_LSB +: THLD_W] = resp_thld_q;
      end
      SEL_DATA_BUF_THLD_CTRL: begin
        own_rdata[THLD_LO_LSB +: THLD_W] = tx_thld_q;
        own_rdata[THLD_HI_LSB +: THLD_W] = rx_thld_q;
      end
      SEL_RESET_CONTROL: own_rdata[NUM_QUEUES-1:0] = rst_bits;
      SEL_QUEUE_STATUS:  own_rdata = queue_status;
      default:           own_rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      own_ack_q   <= 1'b0;
      own_err_q   <= 1'b0;
      own_rdata_q <= '0;
      wr_pend_q   <= 1'b0;
    end else begin
      own_ack_q   <= own_req;
      own_err_q   <= own_req & own_err;
      own_rdata_q <= (own_req & ~own_err & ~csr_wr_i) ? own_rdata : '0;
      if (csr_req_i) wr_pend_q <= csr_wr_i;  // Picks the acknowledge line
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= THLD_W'(THLD_RESET_VAL);
      resp_thld_q <= THLD_W'(THLD_RESET_VAL);
      tx_thld_q   <= THLD_W'(THLD_RESET_VAL);
      rx_thld_q   <= THLD_W'(THLD_RESET_VAL);
    end else if (own_wr && sel == SEL_QUEUE_THLD_CTRL) begin
      cmd_thld_q  <= csr_wdata_i[THLD_LO_LSB +: THLD_W];
      resp_thld_q <= csr_wdata_i[THLD_HI_LSB +: THLD_W];
    end else if (own_wr && sel == SEL_DATA_BUF_THLD_CTRL) begin
      tx_thld_q <= csr_wdata_i[THLD_LO_LSB +: THLD_W];
      rx_thld_q <= csr_wdata_i[THLD_HI_LSB +: THLD_W];
    end
  end

  assign cmd_q.thld  = cmd_thld_q;
  assign resp_q.thld = resp_thld_q;
  assign tx_q.thld   = tx_thld_q;
  assign rx_q.thld   = rx_thld_q;

  assign rst_set = (own_wr && sel == SEL_RESET_CONTROL) ? csr_wdata_i[NUM_QUEUES-1:0] : '0;

  assign flush_done[Q_CMD]  = cmd_q.flush_done;
  assign flush_done[Q_RESP] = resp_q.flush_done;
  assign flush_done[Q_TX]   = tx_q.flush_done;
  assign flush_done[Q_RX]   = rx_q.flush_done;

  // Bit set, then flush, then wait for the queue to report back
  for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_rst_seq
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rst_state_q[i] <= RST_IDLE;
        flush_q[i]     <= 1'b0;
      end else begin
        flush_q[i] <= (rst_state_q[i] == RST_FLUSH);
        case (rst_state_q[i])
          RST_IDLE:  if (rst_set[i]) rst_state_q[i] <= RST_FLUSH;
          RST_FLUSH: rst_state_q[i] <= RST_WAIT;
          RST_WAIT:  if (flush_done[i]) rst_state_q[i] <= RST_IDLE;
          default:   rst_state_q[i] <= RST_IDLE;
        endcase
      end
    end
    assign rst_bits[i] = (rst_state_q[i] != RST_IDLE);  // Self-clearing view
  end

  assign cmd_q.flush  = flush_q[Q_CMD];
  assign resp_q.flush = flush_q[Q_RESP];
  assign tx_q.flush   = flush_q[Q_TX];
  assign rx_q.flush   = flush_q[Q_RX];

  // At most one source acknowledges per cycle
  assign any_ack      = own_ack_q | cmd_q.ack | resp_q.ack | tx_q.ack | rx_q.ack;
  assign csr_wr_ack_o = any_ack & wr_pend_q;
  assign csr_rd_ack_o = any_ack & ~wr_pend_q;
  assign csr_err_o    = own_err_q | cmd_q.err | resp_q.err | tx_q.err | rx_q.err;
  assign csr_rdata_o  = own_rdata_q | cmd_q.rdata | resp_q.rdata | tx_q.rdata | rx_q.rdata;

endmodule : hci_csr_ctrl

// File: hw/hci_fifo.sv
/* Circular-buffer FIFO with occupancy count and flush */
`timescale 1ns/1ns

module hci_fifo (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         push_i,
  input  logic [hci_pkg::DATA_W-1:0]   wdata_i,
  input  logic                         pop_i,
  input  logic                         flush_i,
  output logic [hci_pkg::DATA_W-1:0]   rdata_o,
  output logic [hci_pkg::COUNT_W-1:0]  count_o,
  output logic                         empty_o,
  output logic                         full_o
);
  import hci_pkg::*;

  logic [DATA_W-1:0]              mem_q [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;  // Wrap on power-of-two depth
  logic [COUNT_W-1:0]             count_q;
  logic                           do_push, do_pop;

  assign full_o  = (count_q == COUNT_W'(QUEUE_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin  // Flush wins over push and pop
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= wdata_i;
  end

  assign rdata_o = mem_q[rd_ptr_q];  // Head word
  assign count_o = count_q;

endmodule : hci_fifo

// File: hw/hci_pio.sv
/* PIO block top with register control and four queues */
`timescale 1ns/1ns

module hci_pio (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // CPU register port
  input  logic                       csr_req_i,
  input  logic                       csr_wr_i,
  input  logic [hci_pkg::ADDR_W-1:0] csr_addr_i,
  input  logic [hci_pkg::DATA_W-1:0] csr_wdata_i,
  output logic                       csr_wr_ack_o,
  output logic                       csr_rd_ack_o,
  output logic                       csr_err_o,
  output logic [hci_pkg::DATA_W-1:0] csr_rdata_o,

  // Bus controller side
  output logic                       cmd_rvalid_o,
  input  logic                       cmd_rready_i,
  output logic [hci_pkg::DATA_W-1:0] cmd_rdata_o,
  output logic                       tx_rvalid_o,
  input  logic                       tx_rready_i,
  output logic [hci_pkg::DATA_W-1:0] tx_rdata_o,
  input  logic                       resp_wvalid_i,
  output logic                       resp_wready_o,
  input  logic [hci_pkg::DATA_W-1:0] resp_wdata_i,
  input  logic                       rx_wvalid_i,
  output logic                       rx_wready_o,
  input  logic [hci_pkg::DATA_W-1:0] rx_wdata_i,

  output logic                       cmd_thld_trig_o,
  output logic                       resp_thld_trig_o,
  output logic                       tx_thld_trig_o,
  output logic                       rx_thld_trig_o
);

  hci_queue_if cmd_if ();
  hci_queue_if resp_if ();
  hci_queue_if tx_if ();
  hci_queue_if rx_if ();

  hci_csr_ctrl csr_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_req_i    (csr_req_i),
    .csr_wr_i     (csr_wr_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_wr_ack_o (csr_wr_ack_o),
    .csr_rd_ack_o (csr_rd_ack_o),
    .csr_err_o    (csr_err_o),
    .csr_rdata_o  (csr_rdata_o),
    .cmd_q        (cmd_if.ctrl),
    .resp_q       (resp_if.ctrl),
    .tx_q         (tx_if.ctrl),
    .rx_q         (rx_if.ctrl)
  );

  // CPU to controller
  hci_write_queue cmd_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr         (cmd_if.queue),
    .rvalid_o    (cmd_rvalid_o),
    .rready_i    (cmd_rready_i),
    .rdata_o     (cmd_rdata_o),
    .thld_trig_o (cmd_thld_trig_o)
  );

  hci_write_queue tx_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr         (tx_if.queue),
    .rvalid_o    (tx_rvalid_o),
    .rready_i    (tx_rready_i),
    .rdata_o     (tx_rdata_o),
    .thld_trig_o (tx_thld_trig_o)
  );

  // Controller to CPU
  hci_read_queue resp_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr         (resp_if.queue),
    .wvalid_i    (resp_wvalid_i),
    .wready_o    (resp_wready_o),
    .wdata_i     (resp_wdata_i),
    .thld_trig_o (resp_thld_trig_o)
  );

  hci_read_queue rx_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr         (rx_if.queue),
    .wvalid_i    (rx_wvalid_i),
    .wready_o    (rx_wready_o),
    .wdata_i     (rx_wdata_i),
    .thld_trig_o (rx_thld_trig_o)
  );

endmodule : hci_pio

// File: hw/hci_pkg.sv
/* Shared widths, queue depth, register map, field positions
   and enums of the PIO block */
package hci_pkg;

  localparam int unsigned DATA_W      = 32;
  localparam int unsigned ADDR_W      = 8;
  localparam int unsigned QUEUE_DEPTH = 8;
  localparam int unsigned COUNT_W     = 4;  // Holds 0..QUEUE_DEPTH
  localparam int unsigned THLD_W      = 4;
  localparam int unsigned NUM_QUEUES  = 4;

  // Register map
  localparam logic [ADDR_W-1:0] ADDR_COMMAND_PORT       = 8'h0C;
  localparam logic [ADDR_W-1:0] ADDR_RESPONSE_PORT      = 8'h10;
  localparam logic [ADDR_W-1:0] ADDR_XFER_DATA_PORT     = 8'h14;
  localparam logic [ADDR_W-1:0] ADDR_QUEUE_THLD_CTRL    = 8'h18;
  localparam logic [ADDR_W-1:0] ADDR_DATA_BUF_THLD_CTRL = 8'h1C;
  localparam logic [ADDR_W-1:0] ADDR_RESET_CONTROL      = 8'h20;
  localparam logic [ADDR_W-1:0] ADDR_QUEUE_STATUS       = 8'h24;

  // Threshold fields
  localparam int unsigned THLD_LO_LSB    = 0;  // cmd / tx
  localparam int unsigned THLD_HI_LSB    = 8;  // resp / rx
  localparam int unsigned THLD_RESET_VAL = 1;

  // Queue bit index in RESET_CONTROL and QUEUE_STATUS
  localparam int unsigned Q_CMD  = 0;
  localparam int unsigned Q_RESP = 1;
  localparam int unsigned Q_TX   = 2;
  localparam int unsigned Q_RX   = 3;

  localparam int unsigned STATUS_FULL_LSB = 4;  // Full flags above empty flags

  typedef enum logic [1:0] {
    RST_IDLE,
    RST_FLUSH,
    RST_WAIT
  } rst_state_e;

  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_COMMAND_PORT,
    SEL_RESPONSE_PORT,
    SEL_XFER_DATA_PORT,
    SEL_QUEUE_THLD_CTRL,
    SEL_DATA_BUF_THLD_CTRL,
    SEL_RESET_CONTROL,
    SEL_QUEUE_STATUS
  } csr_sel_e;

endpackage : hci_pkg

// File: hw/hci_queue_if.sv
/* Link between register control and one queue */
`timescale 1ns/1ns

interface hci_queue_if;
  import hci_pkg::*;

  // Control side
  logic              req;    // Port access strobe
  logic [DATA_W-1:0] wdata;
  logic              flush;  // Queue reset strobe
  logic [THLD_W-1:0] thld;

  // Queue side
  logic              ack;    // One cycle after req
  logic              err;
  logic [DATA_W-1:0] rdata;  // Zero outside ack
  logic              flush_done;
  logic              empty;
  logic              full;

  modport ctrl (
    output req, wdata, flush, thld,
    input  ack, err, rdata, flush_done, empty, full
  );

  modport queue (
    input  req, wdata, flush, thld,
    output ack, err, rdata, flush_done, empty, full
  );

endinterface : hci_queue_if

// File: hw/hci_read_queue.sv
/* Controller-filled queue drained by CPU reads
   Serves the response and RX queues */
`timescale 1ns/1ns

module hci_read_queue (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  hci_queue_if.queue                 csr,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [hci_pkg::DATA_W-1:0] wdata_i,
  output logic                       thld_trig_o
);
  import hci_pkg::*;

  logic [DATA_W-1:0]  head;
  logic [COUNT_W-1:0] count;
  logic               empty, full;
  logic               pop;
  logic               ack_q, err_q, flush_done_q;
  logic [DATA_W-1:0]  rdata_q;

  assign pop = csr.req & ~empty;

  hci_fifo fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (wvalid_i & wready_o),
    .wdata_i (wdata_i),
    .pop_i   (pop),
    .flush_i (csr.flush),
    .rdata_o (head),
    .count_o (count),
    .empty_o (empty),
    .full_o  (full)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q        <= 1'b0;
      err_q        <= 1'b0;
      rdata_q      <= '0;
      flush_done_q <= 1'b0;
    end else begin
      ack_q        <= csr.req;
      err_q        <= csr.req & empty;          // Nothing to read
      rdata_q      <= pop ? head : '0;          // Zero outside a good read
      flush_done_q <= csr.flush;
    end
  end

  // Back-pressure toward the controller
  assign wready_o = ~full;

  assign thld_trig_o = (count >= csr.thld);  // Occupancy against threshold

  assign csr.ack        = ack_q;
  assign csr.err        = err_q;
  assign csr.rdata      = rdata_q;
  assign csr.flush_done = flush_done_q;
  assign csr.empty      = empty;
  assign csr.full       = full;

endmodule : hci_read_queue

// File: hw/hci_write_queue.sv
/* CPU-filled queue drained by the bus controller
   Serves the command and TX queues */
`timescale 1ns/1ns

module hci_write_queue (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  hci_queue_if.queue                 csr,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [hci_pkg::DATA_W-1:0] rdata_o,
  output logic                       thld_trig_o
);
  import hci_pkg::*;

  logic [COUNT_W-1:0] count;
  logic               empty, full;
  logic               ack_q, err_q, flush_done_q;
  logic [COUNT_W-1:0] free_cnt;

  hci_fifo fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (csr.req & ~full),  // Word dropped when full
    .wdata_i (csr.wdata),
    .pop_i   (rvalid_o & rready_i),
    .flush_i (csr.flush),
    .rdata_o (rdata_o),
    .count_o (count),
    .empty_o (empty),
    .full_o  (full)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q        <= 1'b0;
      err_q        <= 1'b0;
      flush_done_q <= 1'b0;
    end else begin
      ack_q        <= csr.req;
      err_q        <= csr.req & full;
      flush_done_q <= csr.flush;
    end
  end

  assign rvalid_o = ~empty;

  // Free entries against threshold
  assign free_cnt    = COUNT_W'(QUEUE_DEPTH) - count;
  assign thld_trig_o = (free_cnt >= csr.thld);

  assign csr.ack        = ack_q;
  assign csr.err        = err_q;
  assign csr.rdata      = '0;  // Write-only port
  assign csr.flush_done = flush_done_q;
  assign csr.empty      = empty;
  assign csr.full       = full;

endmodule : hci_write_queue

// File: src.f
hw/hci_pkg.sv
hw/hci_queue_if.sv
hw/hci_fifo.sv
hw/hci_write_queue.sv
hw/hci_read_queue.sv
hw/hci_csr_ctrl.sv
hw/hci_pio.sv
verification/hci_tb_clk_gen.sv
verification/hci_pio_properties.sv
verification/hci_pio_tb.sv

// File: verification/hci_pio_properties.sv
/* Concurrent assertions on the register port and command queue,
   bound to the PIO top */
`timescale 1ns/1ns

module hci_pio_properties (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       csr_req_i,
  input logic                       csr_wr_i,
  input logic [hci_pkg::ADDR_W-1:0] csr_addr_i,
  input logic                       wr_ack_i,
  input logic                       rd_ack_i,
  input logic                       err_i,
  input logic [hci_pkg::DATA_W-1:0] rdata_i,
  input logic                       cmd_rvalid_i,
  input logic                       cmd_flush_i
);
  import hci_pkg::*;

  logic cmd_write;

  assign cmd_write = csr_req_i & csr_wr_i & (csr_addr_i == ADDR_COMMAND_PORT);

  // One acknowledge, on the next edge, on the right line
  a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_req_i |=> (wr_ack_i ^ rd_ack_i))
    else $error("request not followed by exactly one acknowledge");

  a_ack_dir: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (csr_req_i && csr_wr_i) |=> wr_ack_i)
    else $error("write acknowledged on the read line");

  a_ack_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_ack_i || rd_ack_i) |-> $past(csr_req_i))
    else $error("acknowledge without a request");

  a_quiet_bus: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (err_i || rdata_i != '0) |-> (wr_ack_i || rd_ack_i))
    else $error("error or read data outside an acknowledge");

  // Flushed command queue stays empty until the CPU writes it again
  a_flush_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_flush_i |=> !cmd_rvalid_i)
    else $error("command queue valid right after flush");

  a_valid_src: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_rvalid_i) |-> $past(cmd_write))
    else $error("command valid rose without a command write");

endmodule : hci_pio_properties

bind hci_pio hci_pio_properties props_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .csr_req_i    (csr_req_i),
  .csr_wr_i     (csr_wr_i),
  .csr_addr_i   (csr_addr_i),
  .wr_ack_i     (csr_wr_ack_o),
  .rd_ack_i     (csr_rd_ack_o),
  .err_i        (csr_err_o),
  .rdata_i      (csr_rdata_o),
  .cmd_rvalid_i (cmd_rvalid_o),
  .cmd_flush_i  (cmd_if.flush)
);

// File: verification/hci_pio_tb.sv
/* Table-driven testbench for the PIO block with model queues,
   value checker and cycle timeout */
`timescale 1ns/1ns

module hci_pio_tb;
  import hci_pkg::*;

  typedef enum logic [2:0] {
    K_WRITE, K_READ, K_CMD_POP, K_TX_POP, K_RESP_PUSH, K_RX_PUSH, K_TRIG, K_IDLE
  } row_kind_e;

  typedef struct packed {
    row_kind_e         kind;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;    // Write data, pushed word or expected word
    logic              flag;    // Expected error, or expected wready on pushes
    logic [3:0]        trig;    // Indexed by Q_CMD..Q_RX
    logic [1:0]        valid;   // cmd, tx rvalid
    int                cycles;
  } row_t;

  logic clk_i, rst_ni;
  logic csr_req_i, csr_wr_i;
  logic [ADDR_W-1:0] csr_addr_i;
  logic [DATA_W-1:0] csr_wdata_i, csr_rdata_o;
  logic csr_wr_ack_o, csr_rd_ack_o, csr_err_o;
  logic cmd_rvalid_o, cmd_rready_i, tx_rvalid_o, tx_rready_i;
  logic [DATA_W-1:0] cmd_rdata_o, tx_rdata_o, resp_wdata_i, rx_wdata_i;
  logic resp_wvalid_i, resp_wready_o, rx_wvalid_i, rx_wready_o;
  logic cmd_thld_trig_o, resp_thld_trig_o, tx_thld_trig_o, rx_thld_trig_o;

  row_t              table_q[$];
  logic [DATA_W-1:0] cmd_m[$], tx_m[$], resp_m[$], rx_m[$];  // Scoreboard
  logic [THLD_W-1:0] cmd_th, resp_th, tx_th, rx_th;
  int                cycle_cnt = 0;
  int                timeout_limit;

  hci_tb_clk_gen clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  hci_pio dut_i (.*);

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > timeout_limit) begin
      $display("Timeout: the test did not finish within %0d cycles", timeout_limit);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                             input logic [DATA_W-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // Triggers and valids are taken from the model state at add time
  function automatic void push_row(input row_kind_e kind, input logic [ADDR_W-1:0] addr,
                                   input logic [DATA_W-1:0] data, input logic flag,
                                   input int cycles);
    row_t r;
    r.kind        = kind;
    r.addr        = addr;
    r.data        = data;
    r.flag        = flag;
    r.cycles      = cycles;
    r.trig[Q_CMD] = (int'(QUEUE_DEPTH) - cmd_m.size()) >= int'(cmd_th);  // Free entries
    r.trig[Q_TX]  = (int'(QUEUE_DEPTH) - tx_m.size()) >= int'(tx_th);
    r.trig[Q_RESP] = resp_m.size() >= int'(resp_th);                     // Occupancy
    r.trig[Q_RX]  = rx_m.size() >= int'(rx_th);
    r.valid       = {cmd_m.size() != 0, tx_m.size() != 0};
    table_q.push_back(r);
  endfunction

  function automatic logic [DATA_W-1:0] exp_status();
    logic [DATA_W-1:0] s;
    s = '0;
    s[Q_CMD]  = (cmd_m.size() == 0);
    s[Q_RESP] = (resp_m.size() == 0);
    s[Q_TX]   = (tx_m.size() == 0);
    s[Q_RX]   = (rx_m.size() == 0);
    s[STATUS_FULL_LSB + Q_CMD]  = (cmd_m.size() == QUEUE_DEPTH);
    s[STATUS_FULL_LSB + Q_RESP] = (resp_m.size() == QUEUE_DEPTH);
    s[STATUS_FULL_LSB + Q_TX]   = (tx_m.size() == QUEUE_DEPTH);
    s[STATUS_FULL_LSB + Q_RX]   = (rx_m.size() == QUEUE_DEPTH);
    return s;
  endfunction

  function automatic void add_write(input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] data);
    logic err;
    err = 1'b0;
    case (addr)
      ADDR_COMMAND_PORT: begin
        if (cmd_m.size() == QUEUE_DEPTH) err = 1'b1;  // Word dropped
        else cmd_m.push_back(data);
      end
      ADDR_XFER_DATA_PORT: begin
        if (tx_m.size() == QUEUE_DEPTH) err = 1'b1;
        else tx_m.push_back(data);
      end
      ADDR_QUEUE_THLD_CTRL: begin
        cmd_th  = data[THLD_LO_LSB +: THLD_W];
        resp_th = data[THLD_HI_LSB +: THLD_W];
      end
      ADDR_DATA_BUF_THLD_CTRL: begin
        tx_th = data[THLD_LO_LSB +: THLD_W];
        rx_th = data[THLD_HI_LSB +: THLD_W];
      end
      ADDR_RESET_CONTROL: begin
        if (data[Q_CMD]) cmd_m.delete();
        if (data[Q_RESP]) resp_m.delete();
        if (data[Q_TX]) tx_m.delete();
        if (data[Q_RX]) rx_m.delete();
      end
      default: err = 1'b1;  // Unknown, read-only status or response port
    endcase
    push_row(K_WRITE, addr, data, err, 0);
  endfunction

  function automatic void add_read(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] exp;
    logic              err;
    exp = '0;
    err = 1'b0;
    case (addr)
      ADDR_RESPONSE_PORT: begin
        if (resp_m.size() == 0) err = 1'b1;
        else exp = resp_m.pop_front();
      end
      ADDR_XFER_DATA_PORT: begin
        if (rx_m.size() == 0) err = 1'b1;
        else exp = rx_m.pop_front();
      end
      ADDR_QUEUE_THLD_CTRL:    exp = (DATA_W'(resp_th) << THLD_HI_LSB) | DATA_W'(cmd_th);
      ADDR_DATA_BUF_THLD_CTRL: exp = (DATA_W'(rx_th) << THLD_HI_LSB) | DATA_W'(tx_th);
      ADDR_RESET_CONTROL:      exp = '0;  // Sequence long finished
      ADDR_QUEUE_STATUS:       exp = exp_status();
      default:                 err = 1'b1;
    endcase
    push_row(K_READ, addr, exp, err, 0);
  endfunction

  function automatic void add_pushes(input row_kind_e kind, input int n);
    logic [DATA_W-1:0] w;
    for (int i = 0; i < n; i++) begin
      w = $urandom();
      if (kind == K_RESP_PUSH) begin
        push_row(kind, '0, w, resp_m.size() < QUEUE_DEPTH, 0);
        if (resp_m.size() < QUEUE_DEPTH) resp_m.push_back(w);
      end else begin
        push_row(kind, '0, w, rx_m.size() < QUEUE_DEPTH, 0);
        if (rx_m.size() < QUEUE_DEPTH) rx_m.push_back(w);
      end
    end
  endfunction

  function automatic void add_pops(input row_kind_e kind, input int n);
    for (int i = 0; i < n; i++) begin
      if (kind == K_CMD_POP) push_row(kind, '0, cmd_m.pop_front(), 1'b0, 0);
      else push_row(kind, '0, tx_m.pop_front(), 1'b0, 0);
    end
  endfunction

  function automatic void add_port_writes(input logic [ADDR_W-1:0] addr, input int n);
    for (int i = 0; i < n; i++) add_write(addr, $urandom());
  endfunction

  function automatic void build_table();
    cmd_th  = THLD_W'(THLD_RESET_VAL);
    resp_th = THLD_W'(THLD_RESET_VAL);
    tx_th   = THLD_W'(THLD_RESET_VAL);
    rx_th   = THLD_W'(THLD_RESET_VAL);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    add_read(ADDR_QUEUE_THLD_CTRL);
    // Command queue fill, overflow and drain
    add_port_writes(ADDR_COMMAND_PORT, 8);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    add_read(ADDR_QUEUE_STATUS);
    add_port_writes(ADDR_COMMAND_PORT, 1);
    add_pops(K_CMD_POP, 8);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    // Response and RX paths
    add_read(ADDR_RESPONSE_PORT);
    add_read(ADDR_XFER_DATA_PORT);
    add_pushes(K_RESP_PUSH, 3);
    add_pushes(K_RX_PUSH, 3);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    for (int i = 0; i < 3; i++) add_read(ADDR_RESPONSE_PORT);
    for (int i = 0; i < 4; i++) add_read(ADDR_XFER_DATA_PORT);  // Last one empty
    // TX path
    add_port_writes(ADDR_XFER_DATA_PORT, 4);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    add_pops(K_TX_POP, 4);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    // Thresholds, junk between the fields is ignored
    add_write(ADDR_QUEUE_THLD_CTRL, ($urandom() & 32'hFFFF_F0F0) | 32'h0000_0306);
    add_read(ADDR_QUEUE_THLD_CTRL);
    add_write(ADDR_DATA_BUF_THLD_CTRL, ($urandom() & 32'hFFFF_F0F0) | 32'h0000_0402);
    add_read(ADDR_DATA_BUF_THLD_CTRL);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    add_pushes(K_RESP_PUSH, 2);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    add_pushes(K_RESP_PUSH, 1);
    add_port_writes(ADDR_COMMAND_PORT, 3);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    add_pops(K_CMD_POP, 1);
    add_pushes(K_RX_PUSH, 4);
    add_port_writes(ADDR_XFER_DATA_PORT, 6);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    add_port_writes(ADDR_XFER_DATA_PORT, 1);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    // Queue reset of all four queues
    add_write(ADDR_RESET_CONTROL, 32'h0000_000F);
    push_row(K_IDLE, '0, '0, 1'b0, 3);
    add_read(ADDR_RESET_CONTROL);
    add_read(ADDR_QUEUE_STATUS);
    push_row(K_TRIG, '0, '0, 1'b0, 0);
    add_read(ADDR_RESPONSE_PORT);
    // Address errors
    add_read(8'h00);
    add_write(8'h40, $urandom());
    add_write(ADDR_QUEUE_STATUS, $urandom());
    add_read(ADDR_COMMAND_PORT);
  endfunction

  task automatic apply_row(input row_t r);
    logic wr;
    wr = (r.kind == K_WRITE);
    case (r.kind)
      K_WRITE, K_READ: begin
        csr_req_i   = 1'b1;
        csr_wr_i    = wr;
        csr_addr_i  = r.addr;
        csr_wdata_i = wr ? r.data : '0;
        @(negedge clk_i);
        csr_req_i = 1'b0;
        check_value("csr_wr_ack_o", csr_wr_ack_o, wr);
        check_value("csr_rd_ack_o", csr_rd_ack_o, !wr);
        check_value("csr_err_o", csr_err_o, r.flag);
        check_value("csr_rdata_o", csr_rdata_o, wr ? '0 : r.data);
      end
      K_CMD_POP: begin
        check_value("cmd_rvalid_o", cmd_rvalid_o, 1'b1);
        check_value("cmd_rdata_o", cmd_rdata_o, r.data);
        cmd_rready_i = 1'b1;
        @(negedge clk_i);
        cmd_rready_i = 1'b0;
      end
      K_TX_POP: begin
        check_value("tx_rvalid_o", tx_rvalid_o, 1'b1);
        check_value("tx_rdata_o", tx_rdata_o, r.data);
        tx_rready_i = 1'b1;
        @(negedge clk_i);
        tx_rready_i = 1'b0;
      end
      K_RESP_PUSH: begin
        check_value("resp_wready_o", resp_wready_o, r.flag);
        resp_wvalid_i = 1'b1;
        resp_wdata_i  = r.data;
        @(negedge clk_i);
        resp_wvalid_i = 1'b0;
      end
      K_RX_PUSH: begin
        check_value("rx_wready_o", rx_wready_o, r.flag);
        rx_wvalid_i = 1'b1;
        rx_wdata_i  = r.data;
        @(negedge clk_i);
        rx_wvalid_i = 1'b0;
      end
      K_TRIG: begin
        check_value("cmd_thld_trig_o", cmd_thld_trig_o, r.trig[Q_CMD]);
        check_value("resp_thld_trig_o", resp_thld_trig_o, r.trig[Q_RESP]);
        check_value("tx_thld_trig_o", tx_thld_trig_o, r.trig[Q_TX]);
        check_value("rx_thld_trig_o", rx_thld_trig_o, r.trig[Q_RX]);
        check_value("cmd_rvalid_o", cmd_rvalid_o, r.valid[1]);
        check_value("tx_rvalid_o", tx_rvalid_o, r.valid[0]);
      end
      default: repeat (r.cycles) @(negedge clk_i);
    endcase
  endtask

  initial begin
    void'($urandom(32'h1f68));
    csr_req_i     = 1'b0;
    csr_wr_i      = 1'b0;
    csr_addr_i    = '0;
    csr_wdata_i   = '0;
    cmd_rready_i  = 1'b0;
    tx_rready_i   = 1'b0;
    resp_wvalid_i = 1'b0;
    resp_wdata_i  = '0;
    rx_wvalid_i   = 1'b0;
    rx_wdata_i    = '0;
    build_table();
    timeout_limit = table_q.size() * 4 + 100;
    wait (rst_ni);
    @(negedge clk_i);
    foreach (table_q[i]) apply_row(table_q[i]);
    $display("RESULT: PASS");
    $finish;
  end

endmodule : hci_pio_tb

// File: verification/hci_tb_clk_gen.sv
/* Testbench clock and power-on reset */
`timescale 1ns/1ns

module hci_tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  localparam int unsigned HALF_PERIOD = 20;  // 40 ns clock
  localparam int unsigned RST_CYCLES  = 3;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
  end

  always #(HALF_PERIOD) clk_o = ~clk_o;

  // Release on a falling edge, away from the flops
  initial begin
    repeat (RST_CYCLES) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule : hci_tb_clk_gen
